// ==== design/udp_echo_pkg.sv ====
/* Shared constants, header struct and union, and stream beat type
   for the UDP echo responder */
package udp_echo_pkg;

    // Local station
    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Protocol constants
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  REPLY_TTL      = 8'd64;

    // Ethernet + IPv4 + UDP header length in bytes
    localparam int HDR_BYTES = 42;
    localparam int HDR_CNT_W = $clog2(HDR_BYTES);

    // Payload FIFO sizing
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Header fields in wire order, first byte on the wire is most significant
    typedef struct packed {
        // Ethernet II
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        // IPv4 without options
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_dscp_ecn;
        logic [15:0] ip_length;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_checksum;
        logic [31:0] ip_source;
        logic [31:0] ip_dest;
        // UDP
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } frame_hdr_t;

    // Same header word, as bytes for shifting or as named fields
    typedef union packed {
        logic [HDR_BYTES-1:0][7:0] raw;
        frame_hdr_t                fields;
    } frame_hdr_u;

    // One byte-wide stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_stream_t;

endpackage

// ==== design/frame_header_parser.sv ====
/* Receive side header parser: collects the 42 header bytes,
   hands the header on, then forwards the payload stream */
module frame_header_parser
    import udp_echo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Receive stream
    input  byte_stream_t rx,
    input  logic         rx_valid,
    output logic         rx_ready,

    // Parsed header
    output frame_hdr_u   hdr,
    output logic         hdr_valid,
    input  logic         hdr_ready,

    // Payload stream
    output byte_stream_t pay,
    output logic         pay_valid,
    input  logic         pay_ready
);

    typedef enum logic [1:0] {
        S_HDR,
        S_WAIT,
        S_PAY
    } state_t;

    state_t               state;
    logic [HDR_CNT_W-1:0] byte_cnt;
    frame_hdr_u           hdr_reg;
    logic                 rx_fire;

    // Header bytes are always taken, payload only as fast as downstream
    assign rx_ready = (state == S_HDR) || ((state == S_PAY) && pay_ready);
    assign rx_fire  = rx_valid && rx_ready;

    assign hdr       = hdr_reg;
    assign hdr_valid = (state == S_WAIT);

    assign pay       = rx;
    assign pay_valid = (state == S_PAY) && rx_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_HDR;
            byte_cnt <= '0;
        end else begin
            case (state)
                S_HDR: begin
                    if (rx_fire) begin
                        if (rx.last) begin
                            // Early termination, throw the frame away
                            byte_cnt <= '0;
                        end else if (byte_cnt == HDR_CNT_W'(HDR_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state    <= S_WAIT;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_WAIT: begin
                    if (hdr_ready) begin
                        state <= S_PAY;
                    end
                end
                S_PAY: begin
                    if (rx_fire && rx.last) begin
                        state <= S_HDR;
                    end
                end
                default: begin
                    state <= S_HDR;
                end
            endcase
        end
    end

    // Header shift register, first byte ends up in the top byte
    always_ff @(posedge clk) begin
        if ((state == S_HDR) && rx_fire) begin
            hdr_reg.raw <= {hdr_reg.raw[HDR_BYTES-2:0], rx.data};
        end
    end

endmodule

// ==== design/echo_port_filter.sv ====
/* Per-frame echo decision; forwards matching headers and payload,
   sinks everything else */
module echo_port_filter
    import udp_echo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Header from parser
    input  frame_hdr_u   in_hdr,
    input  logic         in_hdr_valid,
    output logic         in_hdr_ready,

    // Header to framer
    output frame_hdr_u   out_hdr,
    output logic         out_hdr_valid,
    input  logic         out_hdr_ready,

    // Payload from parser
    input  byte_stream_t in_pay,
    input  logic         in_pay_valid,
    output logic         in_pay_ready,

    // Payload to FIFO
    output byte_stream_t out_pay,
    output logic         out_pay_valid,
    input  logic         out_pay_ready
);

    logic match;
    logic keep_reg;

    // All four conditions for an echo
    assign match = (in_hdr.fields.eth_type == ETHERTYPE_IPV4) &&
                   (in_hdr.fields.ip_protocol == IP_PROTO_UDP) &&
                   (in_hdr.fields.ip_dest == LOCAL_IP) &&
                   (in_hdr.fields.udp_dest_port == ECHO_PORT);

    assign out_hdr       = in_hdr;
    assign out_hdr_valid = in_hdr_valid && match;
    // Headers we ignore are consumed right away
    assign in_hdr_ready  = match ? out_hdr_ready : 1'b1;

    assign out_pay       = in_pay;
    assign out_pay_valid = in_pay_valid && keep_reg;
    assign in_pay_ready  = keep_reg ? out_pay_ready : 1'b1;

    // Decision for the payload that follows this header
    always_ff @(posedge clk) begin
        if (rst) begin
            keep_reg <= 1'b0;
        end else if (in_hdr_valid && in_hdr_ready) begin
            keep_reg <= match;
        end
    end

endmodule

// ==== design/payload_fifo.sv ====
/* Byte FIFO carrying payload data and last flag
   between the filter and the reply framer */
module payload_fifo
    import udp_echo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Write side
    input  byte_stream_t in,
    input  logic         in_valid,
    output logic         in_ready,

    // Read side
    output byte_stream_t out,
    output logic         out_valid,
    input  logic         out_ready
);

    byte_stream_t          mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out       = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/reply_framer.sv ====
/* Reply framer: swaps addresses and ports, computes the IPv4 checksum,
   sends the header then the payload, and keeps the LED byte */
module reply_framer
    import udp_echo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Header of a frame to echo
    input  frame_hdr_u   hdr,
    input  logic         hdr_valid,
    output logic         hdr_ready,

    // Payload from FIFO
    input  byte_stream_t pay,
    input  logic         pay_valid,
    output logic         pay_ready,

    // Transmit stream
    output byte_stream_t tx,
    output logic         tx_valid,
    input  logic         tx_ready,

    output logic [7:0]   led
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_PAY
    } state_t;

    state_t               state;
    logic [HDR_CNT_W-1:0] byte_cnt;
    logic                 first_pay;
    frame_hdr_u           reply_reg;
    frame_hdr_u           reply_next;

    // Sum of the ten header words, checksum word counted as zero
    function automatic logic [15:0] ip_hdr_checksum(input frame_hdr_t h);
        logic [19:0] sum;
        sum = {h.ip_ver_ihl, h.ip_dscp_ecn} + h.ip_length + h.ip_id +
              h.ip_flags_frag + {h.ip_ttl, h.ip_protocol} +
              h.ip_source[31:16] + h.ip_source[15:0] +
              h.ip_dest[31:16] + h.ip_dest[15:0];
        // Fold carries back in, twice covers the worst case
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        return ~sum[15:0];
    endfunction

    always_comb begin
        reply_next.fields.eth_dest_mac    = hdr.fields.eth_src_mac;
        reply_next.fields.eth_src_mac     = LOCAL_MAC;
        reply_next.fields.eth_type        = ETHERTYPE_IPV4;
        reply_next.fields.ip_ver_ihl      = IP_VER_IHL;
        reply_next.fields.ip_dscp_ecn     = 8'h00;
        reply_next.fields.ip_length       = hdr.fields.ip_length;
        reply_next.fields.ip_id           = 16'h0000;
        reply_next.fields.ip_flags_frag   = 16'h0000;
        reply_next.fields.ip_ttl          = REPLY_TTL;
        reply_next.fields.ip_protocol     = IP_PROTO_UDP;
        reply_next.fields.ip_checksum     = 16'h0000;
        reply_next.fields.ip_source       = LOCAL_IP;
        reply_next.fields.ip_dest         = hdr.fields.ip_source;
        reply_next.fields.udp_source_port = hdr.fields.udp_dest_port;
        reply_next.fields.udp_dest_port   = hdr.fields.udp_source_port;
        reply_next.fields.udp_length      = hdr.fields.udp_length;
        reply_next.fields.udp_checksum    = 16'h0000;
        reply_next.fields.ip_checksum     = ip_hdr_checksum(reply_next.fields);
    end

    assign hdr_ready = (state == S_IDLE);
    assign pay_ready = (state == S_PAY) && tx_ready;

    // Header bytes come from the top of the reply register
    always_comb begin
        if (state == S_HDR) begin
            tx.data  = reply_reg.raw[HDR_BYTES-1];
            tx.last  = 1'b0;
            tx_valid = 1'b1;
        end else begin
            tx       = pay;
            tx_valid = (state == S_PAY) && pay_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            byte_cnt  <= '0;
            first_pay <= 1'b0;
            led       <= 8'h00;
        end else begin
            case (state)
                S_IDLE: begin
                    if (hdr_valid) begin
                        state    <= S_HDR;
                        byte_cnt <= '0;
                    end
                end
                S_HDR: begin
                    if (tx_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == HDR_CNT_W'(HDR_BYTES - 1)) begin
                            state     <= S_PAY;
                            first_pay <= 1'b1;
                        end
                    end
                end
                S_PAY: begin
                    if (pay_valid && tx_ready) begin
                        if (first_pay) begin
                            led       <= pay.data;
                            first_pay <= 1'b0;
                        end
                        if (pay.last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Load on acceptance, then shift one byte per transfer
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && hdr_valid) begin
            reply_reg <= reply_next;
        end else if ((state == S_HDR) && tx_ready) begin
            reply_reg.raw <= {reply_reg.raw[HDR_BYTES-2:0], 8'h00};
        end
    end

endmodule

// ==== design/udp_echo_core.sv ====
/* UDP echo responder top level */
module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  byte_stream_t rx,
    input  logic         rx_valid,
    output logic         rx_ready,

    output byte_stream_t tx,
    output logic         tx_valid,
    input  logic         tx_ready,

    output logic [7:0]   led
);

    // Parser to filter
    frame_hdr_u   parse_hdr;
    logic         parse_hdr_valid;
    logic         parse_hdr_ready;
    byte_stream_t parse_pay;
    logic         parse_pay_valid;
    logic         parse_pay_ready;

    // Filter to framer and FIFO
    frame_hdr_u   echo_hdr;
    logic         echo_hdr_valid;
    logic         echo_hdr_ready;
    byte_stream_t echo_pay;
    logic         echo_pay_valid;
    logic         echo_pay_ready;

    // FIFO to framer
    byte_stream_t fifo_pay;
    logic         fifo_pay_valid;
    logic         fifo_pay_ready;

    frame_header_parser parser_i (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .hdr       (parse_hdr),
        .hdr_valid (parse_hdr_valid),
        .hdr_ready (parse_hdr_ready),
        .pay       (parse_pay),
        .pay_valid (parse_pay_valid),
        .pay_ready (parse_pay_ready)
    );

    echo_port_filter filter_i (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (parse_hdr),
        .in_hdr_valid  (parse_hdr_valid),
        .in_hdr_ready  (parse_hdr_ready),
        .out_hdr       (echo_hdr),
        .out_hdr_valid (echo_hdr_valid),
        .out_hdr_ready (echo_hdr_ready),
        .in_pay        (parse_pay),
        .in_pay_valid  (parse_pay_valid),
        .in_pay_ready  (parse_pay_ready),
        .out_pay       (echo_pay),
        .out_pay_valid (echo_pay_valid),
        .out_pay_ready (echo_pay_ready)
    );

    payload_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in        (echo_pay),
        .in_valid  (echo_pay_valid),
        .in_ready  (echo_pay_ready),
        .out       (fifo_pay),
        .out_valid (fifo_pay_valid),
        .out_ready (fifo_pay_ready)
    );

    reply_framer framer_i (
        .clk       (clk),
        .rst       (rst),
        .hdr       (echo_hdr),
        .hdr_valid (echo_hdr_valid),
        .hdr_ready (echo_hdr_ready),
        .pay       (fifo_pay),
        .pay_valid (fifo_pay_valid),
        .pay_ready (fifo_pay_ready),
        .tx        (tx),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .led       (led)
    );

endmodule

// ==== tests/udp_echo_tb.sv ====
/* Testbench for the UDP echo responder: frame builder, reply model,
   directed tests, tx capture and watchdog */
module udp_echo_tb
    import udp_echo_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int SETTLE_CYCLES   = 100;
    localparam int MAX_FRAMES      = 30;
    localparam int TEST_CYCLES     = MAX_FRAMES * 2 * (HDR_BYTES + 100) + 20 * SETTLE_CYCLES;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    typedef logic [7:0] byte_q_t[$];
    typedef byte_stream_t beat_q_t[$];

    // Request fields that the tests vary
    typedef struct packed {
        logic [47:0] src_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] eth_type;
        logic [7:0]  proto;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } frame_cfg_t;

    logic         clk;
    logic         rst;
    byte_stream_t rx;
    logic         rx_valid;
    logic         rx_ready;
    byte_stream_t tx;
    logic         tx_valid;
    logic         tx_ready;
    logic [7:0]   led;
    logic         bp_on;

    beat_q_t cap_q;
    beat_q_t exp_q;
    int      errors;
    int      err_mark;
    int      tests_passed;
    int      tests_failed;

    udp_echo_core dut_i (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx       (tx),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // tx_ready random only while back-pressure is on
    initial begin
        tx_ready = 1'b1;
        forever begin
            @(negedge clk);
            tx_ready = bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    // A beat seen in the low phase transfers on the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            #5;
            if (!rst && tx_valid && tx_ready) begin
                cap_q.push_back(tx);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic frame_cfg_t good_cfg();
        frame_cfg_t c;
        c.src_mac  = 48'h00_1a_2b_3c_4d_5e;
        c.src_ip   = {8'd192, 8'd168, 8'd1, 8'd20};
        c.dst_ip   = LOCAL_IP;
        c.eth_type = ETHERTYPE_IPV4;
        c.proto    = IP_PROTO_UDP;
        c.src_port = 16'd40000;
        c.dst_port = ECHO_PORT;
        return c;
    endfunction

    function automatic byte_q_t rand_payload(input int n);
        byte_q_t p;
        int      i;
        for (i = 0; i < n; i++) begin
            p.push_back(8'($urandom));
        end
        return p;
    endfunction

    // Request header in wire order with arbitrary id, TTL and checksums
    function automatic byte_q_t make_frame(input frame_cfg_t cfg, input byte_q_t payload);
        byte_q_t      f;
        logic [335:0] h;
        int           i;
        h = {LOCAL_MAC, cfg.src_mac, cfg.eth_type, 8'h45, 8'h00,
             16'(28 + payload.size()), 16'h1c46, 16'h4000, 8'h80, cfg.proto, 16'hbeef,
             cfg.src_ip, cfg.dst_ip, cfg.src_port, cfg.dst_port,
             16'(8 + payload.size()), 16'h0000};
        for (i = 0; i < HDR_BYTES; i++) begin
            f.push_back(h[335 - 8 * i -: 8]);
        end
        foreach (payload[k]) begin
            f.push_back(payload[k]);
        end
        return f;
    endfunction

    function automatic logic [47:0] get_field(input byte_q_t r, input int off, input int n);
        logic [47:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[39:0], r[off + i]};
        end
        return v;
    endfunction

    // Expected reply beats for one request frame
    function automatic beat_q_t model_reply(input byte_q_t r);
        beat_q_t      q;
        logic [335:0] h;
        logic [31:0]  sum;
        int           i;
        h = {get_field(r, 6, 6), LOCAL_MAC, ETHERTYPE_IPV4, IP_VER_IHL, 8'h00,
             16'(get_field(r, 16, 2)), 32'h0, REPLY_TTL, IP_PROTO_UDP, 16'h0000,
             LOCAL_IP, 32'(get_field(r, 26, 4)), 16'(get_field(r, 36, 2)),
             16'(get_field(r, 34, 2)), 16'(get_field(r, 38, 2)), 16'h0000};
        // IPv4 header spans bytes 14 to 33
        sum = '0;
        for (i = 0; i < 10; i++) begin
            sum = sum + 32'(h[335 - (14 + 2 * i) * 8 -: 16]);
        end
        while (sum[31:16] != 16'h0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        h[335 - 24 * 8 -: 16] = ~sum[15:0];
        for (i = 0; i < HDR_BYTES; i++) begin
            q.push_back({h[335 - 8 * i -: 8], 1'b0});
        end
        for (i = HDR_BYTES; i < r.size(); i++) begin
            q.push_back({r[i], i == r.size() - 1});
        end
        return q;
    endfunction

    task automatic send_frame(input byte_q_t f);
        int   i;
        logic taken;
        for (i = 0; i < f.size(); i++) begin
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                rx.data  = f[i];
                rx.last  = (i == f.size() - 1);
                rx_valid = 1'b1;
                #1;
                taken = rx_ready;
            end
        end
    endtask

    task automatic send_and_expect(input byte_q_t f, input logic echoed);
        beat_q_t r;
        if (echoed) begin
            r = model_reply(f);
            foreach (r[k]) begin
                exp_q.push_back(r[k]);
            end
        end
        send_frame(f);
    endtask

    // Wait for the expected reply bytes and a quiet period that catches extra ones
    task automatic finish_check(input string name);
        int waited;
        int n;
        int i;
        @(negedge clk);
        rx_valid = 1'b0;
        waited   = 0;
        while ((cap_q.size() < exp_q.size()) && (waited < 8 * exp_q.size() + 300)) begin
            @(negedge clk);
            waited++;
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (cap_q.size() < exp_q.size()) begin
            $display("%s: %0d reply bytes never came out", name, exp_q.size() - cap_q.size());
            errors++;
        end else if (cap_q.size() > exp_q.size()) begin
            $display("%s: %0d unexpected extra bytes on tx", name, cap_q.size() - exp_q.size());
            errors++;
        end
        n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
        for (i = 0; i < n; i++) begin
            check_value(name, 32'(exp_q[i]), 32'(cap_q[i]));
        end
        cap_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    task automatic led_test();
        byte_q_t    p;
        frame_cfg_t c;
        check_value("led_after_reset", 32'h0, 32'(led));
        check_value("rx_ready_after_reset", 32'h1, 32'(rx_ready));
        check_value("tx_valid_after_reset", 32'h0, 32'(tx_valid));
        p = rand_payload(6);
        p[0] = 8'ha5;
        send_and_expect(make_frame(good_cfg(), p), 1'b1);
        finish_check("led_echo");
        check_value("led_echo", 32'ha5, 32'(led));
        c = good_cfg();
        c.dst_port = 16'd4321;
        p[0] = 8'h3c;
        send_and_expect(make_frame(c, p), 1'b0);
        finish_check("led_drop");
        check_value("led_drop", 32'ha5, 32'(led));
        end_test("led_test");
    endtask

    task automatic basic_echo_test();
        send_and_expect(make_frame(good_cfg(), rand_payload(10)), 1'b1);
        finish_check("basic_echo");
        end_test("basic_echo_test");
    endtask

    task automatic drop_test();
        frame_cfg_t c;
        c = good_cfg();
        c.dst_port = ECHO_PORT + 16'd1;
        send_and_expect(make_frame(c, rand_payload(8)), 1'b0);
        c = good_cfg();
        c.dst_ip = {8'd192, 8'd168, 8'd1, 8'd129};
        send_and_expect(make_frame(c, rand_payload(8)), 1'b0);
        c = good_cfg();
        c.eth_type = 16'h86dd;
        send_and_expect(make_frame(c, rand_payload(8)), 1'b0);
        c = good_cfg();
        c.proto = 8'd6;
        send_and_expect(make_frame(c, rand_payload(8)), 1'b0);
        send_and_expect(make_frame(good_cfg(), rand_payload(12)), 1'b1);
        finish_check("drop");
        end_test("drop_test");
    endtask

    task automatic short_frame_test();
        byte_q_t f;
        byte_q_t empty;
        byte_q_t cut;
        f = make_frame(good_cfg(), rand_payload(5));
        for (int i = 0; i < 20; i++) begin
            cut.push_back(f[i]);
        end
        send_and_expect(cut, 1'b0);
        // Header only with last on byte 42
        send_and_expect(make_frame(good_cfg(), empty), 1'b0);
        send_and_expect(f, 1'b1);
        finish_check("short_frame");
        end_test("short_frame_test");
    endtask

    task automatic burst_test();
        int k;
        for (k = 0; k < 5; k++) begin
            send_and_expect(make_frame(good_cfg(), rand_payload($urandom_range(1, 100))), 1'b1);
        end
        finish_check("burst");
        end_test("burst_test");
    endtask

    // Sends the same frames again with tx_ready toggling
    task automatic backpressure_test();
        byte_q_t all_bytes;
        byte_q_t f;
        int      lens[$];
        int      k;
        int      pos;
        for (k = 0; k < 5; k++) begin
            f = make_frame(good_cfg(), rand_payload($urandom_range(1, 100)));
            lens.push_back(f.size());
            foreach (f[j]) begin
                all_bytes.push_back(f[j]);
            end
            send_and_expect(f, 1'b1);
        end
        finish_check("bp_reference");
        bp_on = 1'b1;
        pos   = 0;
        for (k = 0; k < 5; k++) begin
            f.delete();
            for (int j = 0; j < lens[k]; j++) begin
                f.push_back(all_bytes[pos + j]);
            end
            pos += lens[k];
            send_and_expect(f, 1'b1);
        end
        finish_check("backpressure");
        bp_on = 1'b0;
        end_test("backpressure_test");
    endtask

    initial begin
        void'($urandom(98677));
        rst          = 1'b1;
        rx           = '0;
        rx_valid     = 1'b0;
        bp_on        = 1'b0;
        errors       = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        led_test();
        basic_echo_test();
        drop_test();
        short_frame_test();
        burst_test();
        backpressure_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/udp_echo_pkg.sv
design/frame_header_parser.sv
design/echo_port_filter.sv
design/payload_fifo.sv
design/reply_framer.sv
design/udp_echo_core.sv
tests/udp_echo_tb.sv

// ==== Makefile ====
TOP = udp_echo_tb

.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
